/* files.f */
bus_pkg.sv
cpu_addr_decoder.sv
bank_registers.sv
bus_cycle_latch.sv
cpu_read_return.sv
bus_controller.sv
bus_controller_properties.sv
tb_bus_controller.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_bus_controller
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_bus_controller.sv */
// testbench for the bus controller, runs a table of cpu cycles and checks selects, addresses and data
`timescale 1ns/10ps

module tb_bus_controller import bus_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS = 22;

    // active-high view of the outputs, {sram, vera, aura, enet, rd, wr, bootrom, scrb, via1}
    localparam logic [8:0] V_SRAM = 9'h100;
    localparam logic [8:0] V_VERA = 9'h080;
    localparam logic [8:0] V_AURA = 9'h040;
    localparam logic [8:0] V_ENET = 9'h020;
    localparam logic [8:0] V_RD = 9'h010;
    localparam logic [8:0] V_WR = 9'h008;
    localparam logic [8:0] V_BOOT = 9'h004;
    localparam logic [8:0] V_SCRB = 9'h002;
    localparam logic [8:0] V_VIA1 = 9'h001;

    // where the expected cpu_db_o of a row comes from
    localparam logic [1:0] DB_NONE = 2'd0;
    localparam logic [1:0] DB_MEM = 2'd1;
    localparam logic [1:0] DB_SLV = 2'd2;
    localparam logic [1:0] DB_VAL = 2'd3;

    typedef struct packed {
        logic [CPU_AW-1:0]  addr;
        logic               rwn;
        logic [DATA_W-1:0]  wdata;
        logic [DATA_W-1:0]  mem_data;
        logic [DATA_W-1:0]  slv_data;
        logic [DATA_W-1:0]  mask;
        logic [8:0]         exp_sel;
        logic [MEM_AHW-1:0] exp_abh;
        logic               chk_db;
        logic [DATA_W-1:0]  exp_db;
    } row_t;

    logic clk6x;
    logic resetn;
    logic [DATA_W-1:0] cpu_db_o, cpu_db_i, mem_db_i, mem_db_o, nora_slv_data_i, rambank_mask_i;
    logic [CPU_AW-1:ABL_W] cpu_abh_i;
    logic cpu_rw_i;
    logic [MEM_AHW-1:0] mem_abh_o;
    logic [ABL_W-1:0] memcpu_abl_o, memcpu_abl_i;
    logic mem_rdn_o, mem_wrn_o, sram_csn_o, vera_csn_o, aura_csn_o, enet_csn_o;
    logic setup_cs, release_wr, release_cs;
    logic [CPU_AW-1:0] nora_slv_addr_o;
    logic [DATA_W-1:0] nora_slv_datawr_o;
    logic nora_slv_datawr_valid, nora_slv_rwn_o;
    logic nora_slv_req_bootrom_o, nora_slv_req_scrb_o, nora_slv_req_via1_o;

    row_t              rows [NUM_ROWS];
    string             row_name [NUM_ROWS];
    int                n_rows;
    int                err_count;
    int                n_pass;
    logic [31:0]       lfsr_state;
    logic [DATA_W-1:0] rnd [9];
    logic [DATA_W-1:0] rb;

    bus_controller u_bus_controller (.*);

    always #(CLK_PERIOD / 2) clk6x = ~clk6x;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_byte(output logic [DATA_W-1:0] value);
        int i;
        value = '0;
        for (i = 0; i < DATA_W; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [8:0] sel_vector();
        return {!sram_csn_o, !vera_csn_o, !aura_csn_o, !enet_csn_o, !mem_rdn_o, !mem_wrn_o,
                nora_slv_req_bootrom_o, nora_slv_req_scrb_o, nora_slv_req_via1_o};
    endfunction

    task automatic compare(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %0s %0s: expected %0h actual %0h", test, what, expected, actual);
            err_count++;
        end
    endtask

    // memory and slave data differ per row so a held cpu_db_o cannot pass by chance
    task automatic add_row(input string name, input logic [CPU_AW-1:0] addr, input logic rwn,
                           input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] mask,
                           input logic [8:0] exp_sel, input logic [MEM_AHW-1:0] exp_abh,
                           input logic [1:0] db_src, input logic [DATA_W-1:0] db_val);
        row_t r;
        r.addr = addr;
        r.rwn = rwn;
        r.wdata = wdata;
        r.mem_data = {n_rows[3:0], 4'h9};
        r.slv_data = {~n_rows[3:0], 4'h6};
        r.mask = mask;
        r.exp_sel = exp_sel;
        r.exp_abh = exp_abh;
        r.chk_db = (db_src != DB_NONE);
        r.exp_db = (db_src == DB_MEM) ? r.mem_data : (db_src == DB_SLV) ? r.slv_data : db_val;
        rows[n_rows] = r;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    // setup, two cycles to sample, read data a cycle later, then release_wr and release_cs
    task automatic run_cycle(input int idx);
        row_t  r;
        string name;
        int    errs_before;
        r = rows[idx];
        name = row_name[idx];
        errs_before = err_count;
        @(negedge clk6x);
        cpu_abh_i = r.addr[CPU_AW-1:ABL_W];
        memcpu_abl_i = r.addr[ABL_W-1:0];
        cpu_rw_i = r.rwn;
        cpu_db_i = r.wdata;
        mem_db_i = r.mem_data;
        nora_slv_data_i = r.slv_data;
        rambank_mask_i = r.mask;
        setup_cs = 1'b1;
        @(negedge clk6x);
        setup_cs = 1'b0;
        @(negedge clk6x);
        compare(name, "selects", 32'(r.exp_sel), 32'(sel_vector()));
        // high address only meaningful when sram is selected
        if (r.exp_sel[8])
        begin
            compare(name, "mem_abh_o", 32'(r.exp_abh), 32'(mem_abh_o));
        end
        compare(name, "memcpu_abl_o", 32'(r.addr[ABL_W-1:0]), 32'(memcpu_abl_o));
        compare(name, "slv addr", 32'(r.addr), 32'(nora_slv_addr_o));
        compare(name, "slv rwn", 32'(r.rwn), 32'(nora_slv_rwn_o));
        compare(name, "datawr_valid idle", 32'(0), 32'(nora_slv_datawr_valid));
        if (!r.rwn)
        begin
            compare(name, "mem_db_o", 32'(r.wdata), 32'(mem_db_o));
            compare(name, "slv datawr", 32'(r.wdata), 32'(nora_slv_datawr_o));
        end
        @(negedge clk6x);
        if (r.chk_db)
        begin
            compare(name, "cpu_db_o", 32'(r.exp_db), 32'(cpu_db_o));
        end
        release_wr = 1'b1;
        @(negedge clk6x);
        release_wr = 1'b0;
        // only the write strobe may have moved
        compare(name, "after release_wr", 32'(r.exp_sel & ~V_WR), 32'(sel_vector()));
        release_cs = 1'b1;
        #1;
        compare(name, "datawr_valid", 32'(1), 32'(nora_slv_datawr_valid));
        @(negedge clk6x);
        release_cs = 1'b0;
        compare(name, "after release_cs", 32'(0), 32'(sel_vector()));
        if (err_count == errs_before)
        begin
            n_pass++;
        end
        $display("test %0s: %0s", name, (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial
    begin
        int i;
        clk6x = 1'b0;
        resetn = 1'b0;
        cpu_db_i = '0;
        cpu_abh_i = '0;
        cpu_rw_i = 1'b1;
        memcpu_abl_i = '0;
        mem_db_i = '0;
        nora_slv_data_i = '0;
        rambank_mask_i = 8'hff;
        setup_cs = 1'b0;
        release_wr = 1'b0;
        release_cs = 1'b0;
        n_rows = 0;
        err_count = 0;
        n_pass = 0;
        lfsr_state = 32'hfb3b;
        for (i = 0; i < 9; i++)
        begin
            take_byte(rnd[i]);
        end
        // rambank value and mask, then a rombank value in the boot rom range
        rb = rnd[0] & rnd[1];
        rnd[2] = rnd[2] | 8'h20;

        add_row("via1_rd", 16'h9F00, 1'b1, 8'h00, 8'hff, V_VIA1, '0, DB_SLV, 8'h00);
        add_row("vera_rd", 16'h9F27, 1'b1, 8'h00, 8'hff, V_VERA | V_RD, '0, DB_MEM, 8'h00);
        add_row("vera_hi_wr", 16'h9F3F, 1'b0, rnd[3], 8'hff, V_VERA | V_WR, '0, DB_NONE, 8'h00);
        add_row("aura_rd", 16'h9F41, 1'b1, 8'h00, 8'hff, V_AURA | V_RD, '0, DB_MEM, 8'h00);
        add_row("scrb_rd", 16'h9F5A, 1'b1, 8'h00, 8'hff, V_SCRB, '0, DB_SLV, 8'h00);
        add_row("enet_wr", 16'h9F80, 1'b0, rnd[4], 8'hff, V_ENET | V_WR, '0, DB_NONE, 8'h00);
        add_row("io_unused_rd", 16'h9F60, 1'b1, 8'h00, 8'hff, '0, '0, DB_NONE, 8'h00);
        add_row("io_unused_wr", 16'h9FF0, 1'b0, rnd[5], 8'hff, '0, '0, DB_NONE, 8'h00);
        add_row("lowmem_rd", 16'h1234, 1'b1, 8'h00, 8'hff, V_SRAM | V_RD,
                {LOWMEM_PAGE_BASE, 4'h1}, DB_MEM, 8'h00);
        add_row("lowmem_wr", 16'h7FFF, 1'b0, rnd[6], 8'hff, V_SRAM | V_WR,
                {LOWMEM_PAGE_BASE, 4'h7}, DB_NONE, 8'h00);
        // rombank 31 after reset has bit 5 clear, so the rom area maps to sram
        add_row("rom_reset_rd", 16'hC000, 1'b1, 8'h00, 8'hff, V_SRAM | V_RD,
                {2'b11, 5'd31, 2'b00}, DB_MEM, 8'h00);
        add_row("rambank_wr", 16'h0000, 1'b0, rnd[0], rnd[1], '0, '0, DB_NONE, 8'h00);
        add_row("rambank_rd", 16'h0000, 1'b1, 8'h00, 8'hff, '0, '0, DB_VAL, rb);
        add_row("ram_rd", 16'hA123, 1'b1, 8'h00, 8'hff, V_SRAM | V_RD, {rb, 1'b0}, DB_MEM, 8'h00);
        add_row("ram_wr", 16'hBFFF, 1'b0, rnd[7], 8'hff, V_SRAM | V_WR, {rb, 1'b1}, DB_NONE, 8'h00);
        add_row("rombank_wr", 16'h0001, 1'b0, rnd[2], 8'hff, '0, '0, DB_NONE, 8'h00);
        add_row("rombank_rd", 16'h0001, 1'b1, 8'h00, 8'hff, '0, '0, DB_VAL, {2'b00, rnd[2][5:0]});
        add_row("bootrom_rd", 16'hE000, 1'b1, 8'h00, 8'hff, V_BOOT, '0, DB_SLV, 8'h00);
        // upper data bits are dropped, leaves rombank 3
        add_row("rombank3_wr", 16'h0001, 1'b0, 8'hc3, 8'hff, '0, '0, DB_NONE, 8'h00);
        add_row("rom_sram_rd", 16'hD000, 1'b1, 8'h00, 8'hff, V_SRAM | V_RD,
                {2'b11, 5'd3, 2'b01}, DB_MEM, 8'h00);
        // writes to rom banks get a select but no write strobe
        add_row("rom_sram_wr", 16'hF800, 1'b0, rnd[8], 8'hff, V_SRAM,
                {2'b11, 5'd3, 2'b11}, DB_NONE, 8'h00);
        add_row("lowmem_0002_rd", 16'h0002, 1'b1, 8'h00, 8'hff, V_SRAM | V_RD,
                {LOWMEM_PAGE_BASE, 4'h0}, DB_MEM, 8'h00);

        repeat (RESET_CYCLES) @(negedge clk6x);
        resetn = 1'b1;
        compare("reset", "selects", 32'(0), 32'(sel_vector()));
        for (i = 0; i < n_rows; i++)
        begin
            run_cycle(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 n_rows, n_pass, n_rows - n_pass, err_count);
        if (err_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // each row takes six cycles, twenty leaves ample margin
    initial
    begin
        #((RESET_CYCLES + NUM_ROWS * 20) * CLK_PERIOD);
        $display("timeout: the bus cycles did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bus_controller_properties.sv */
// assertions on strobes and chip-selects of the cycle latch, attached by bind from this file
`timescale 1ns/10ps

module bus_controller_properties
(
    input logic clk6x,
    input logic resetn,
    input logic release_cs_i,
    input logic sram_csn_o,
    input logic vera_csn_o,
    input logic aura_csn_o,
    input logic enet_csn_o,
    input logic mem_rdn_o,
    input logic mem_wrn_o,
    input logic slv_req_bootrom_o,
    input logic slv_req_scrb_o,
    input logic slv_req_via1_o,
    input logic bankreg_sel_o
);

    logic all_idle;

    // every select, strobe and request in its inactive state
    assign all_idle = sram_csn_o && vera_csn_o && aura_csn_o && enet_csn_o
                      && mem_rdn_o && mem_wrn_o && !slv_req_bootrom_o
                      && !slv_req_scrb_o && !slv_req_via1_o && !bankreg_sel_o;

    // read and write strobe never together
    assert property (@(posedge clk6x) disable iff (!resetn) !(!mem_rdn_o && !mem_wrn_o))
        else $error("mem_rdn_o and mem_wrn_o low at the same time");

    // one external device at a time
    assert property (@(posedge clk6x) disable iff (!resetn)
                     $onehot0({!sram_csn_o, !vera_csn_o, !aura_csn_o, !enet_csn_o}))
        else $error("more than one external chip-select low");

    assert property (@(posedge clk6x) disable iff (!resetn) release_cs_i |=> all_idle)
        else $error("selects still active the cycle after release_cs");

endmodule

bind bus_cycle_latch bus_controller_properties u_bus_controller_properties (
    .clk6x             (clk6x),
    .resetn            (resetn),
    .release_cs_i      (release_cs_i),
    .sram_csn_o        (sram_csn_o),
    .vera_csn_o        (vera_csn_o),
    .aura_csn_o        (aura_csn_o),
    .enet_csn_o        (enet_csn_o),
    .mem_rdn_o         (mem_rdn_o),
    .mem_wrn_o         (mem_wrn_o),
    .slv_req_bootrom_o (slv_req_bootrom_o),
    .slv_req_scrb_o    (slv_req_scrb_o),
    .slv_req_via1_o    (slv_req_via1_o),
    .bankreg_sel_o     (bankreg_sel_o)
);

/* bus_controller.sv */
// top of the cpu side bus controller, connects decoder, cycle latch, bank registers and read return
`timescale 1ns/10ps

module bus_controller import bus_pkg::*;
(
    // 48 MHz system clock
    input  logic                    clk6x,
    input  logic                    resetn,
    // cpu data and address
    output logic [DATA_W-1:0]       cpu_db_o,
    input  logic [DATA_W-1:0]       cpu_db_i,
    input  logic [CPU_AW-1:ABL_W]   cpu_abh_i,
    input  logic                    cpu_rw_i,
    // memory bus, low address shared with the cpu
    output logic [MEM_AHW-1:0]      mem_abh_o,
    output logic [ABL_W-1:0]        memcpu_abl_o,
    input  logic [ABL_W-1:0]        memcpu_abl_i,
    input  logic [DATA_W-1:0]       mem_db_i,
    output logic [DATA_W-1:0]       mem_db_o,
    // external strobes and selects
    output logic                    mem_rdn_o,
    output logic                    mem_wrn_o,
    output logic                    sram_csn_o,
    output logic                    vera_csn_o,
    output logic                    aura_csn_o,
    output logic                    enet_csn_o,
    // cpu cycle phases from the clock phaser
    input  logic                    setup_cs,
    input  logic                    release_wr,
    input  logic                    release_cs,
    // internal slave side
    output logic [CPU_AW-1:0]       nora_slv_addr_o,
    output logic [DATA_W-1:0]       nora_slv_datawr_o,
    output logic                    nora_slv_datawr_valid,
    input  logic [DATA_W-1:0]       nora_slv_data_i,
    output logic                    nora_slv_req_bootrom_o,
    output logic                    nora_slv_req_scrb_o,
    output logic                    nora_slv_req_via1_o,
    output logic                    nora_slv_rwn_o,
    // usable ram banks, from scrb
    input  logic [DATA_W-1:0]       rambank_mask_i
);

    cpu_cycle_t           cpu_cycle;
    cpu_cycle_t           slv_cycle;
    bus_sel_t             dec_sel;
    logic [MEM_AHW-1:0]   dec_abh;
    logic [RAMBANK_W-1:0] rambank;
    logic [ROMBANK_W-1:0] rombank;
    logic                 bankreg_sel;
    logic                 int_req;

    // full cpu address from the two halves
    assign cpu_cycle.addr = {cpu_abh_i, memcpu_abl_i};
    assign cpu_cycle.rwn = cpu_rw_i;

    // write data is only stable at the end of the cycle
    assign mem_db_o = cpu_db_i;
    assign nora_slv_datawr_o = cpu_db_i;
    assign nora_slv_datawr_valid = release_cs;

    assign nora_slv_addr_o = slv_cycle.addr;
    assign nora_slv_rwn_o = slv_cycle.rwn;
    // any internal slave with its own read data
    assign int_req = nora_slv_req_bootrom_o || nora_slv_req_scrb_o || nora_slv_req_via1_o;

    cpu_addr_decoder u_cpu_addr_decoder (
        .cycle_i   (cpu_cycle),
        .rambank_i (rambank),
        .rombank_i (rombank),
        .sel_o     (dec_sel),
        .mem_abh_o (dec_abh)
    );

    bus_cycle_latch u_bus_cycle_latch (
        .clk6x             (clk6x),
        .resetn            (resetn),
        .setup_cs_i        (setup_cs),
        .release_wr_i      (release_wr),
        .release_cs_i      (release_cs),
        .cycle_i           (cpu_cycle),
        .sel_i             (dec_sel),
        .mem_abh_i         (dec_abh),
        .abl_i             (memcpu_abl_i),
        .mem_abh_o         (mem_abh_o),
        .memcpu_abl_o      (memcpu_abl_o),
        .sram_csn_o        (sram_csn_o),
        .vera_csn_o        (vera_csn_o),
        .aura_csn_o        (aura_csn_o),
        .enet_csn_o        (enet_csn_o),
        .mem_rdn_o         (mem_rdn_o),
        .mem_wrn_o         (mem_wrn_o),
        .slv_req_bootrom_o (nora_slv_req_bootrom_o),
        .slv_req_scrb_o    (nora_slv_req_scrb_o),
        .slv_req_via1_o    (nora_slv_req_via1_o),
        .bankreg_sel_o     (bankreg_sel),
        .slv_cycle_o       (slv_cycle)
    );

    bank_registers u_bank_registers (
        .clk6x          (clk6x),
        .resetn         (resetn),
        .release_cs_i   (release_cs),
        .bankreg_sel_i  (bankreg_sel),
        .cycle_i        (slv_cycle),
        .wdata_i        (cpu_db_i),
        .rambank_mask_i (rambank_mask_i),
        .rambank_o      (rambank),
        .rombank_o      (rombank)
    );

    cpu_read_return u_cpu_read_return (
        .clk6x         (clk6x),
        .mem_rdn_i     (mem_rdn_o),
        .bankreg_sel_i (bankreg_sel),
        .slv_addr0_i   (slv_cycle.addr[0]),
        .int_req_i     (int_req),
        .rambank_i     (rambank),
        .rombank_i     (rombank),
        .mem_db_i      (mem_db_i),
        .slv_data_i    (nora_slv_data_i),
        .cpu_db_o      (cpu_db_o)
    );

endmodule

/* cpu_read_return.sv */
// registered read data toward the cpu, picked from memory, bank registers or internal slaves
`timescale 1ns/10ps

module cpu_read_return import bus_pkg::*;
(
    input  logic                 clk6x,
    // external read in progress
    input  logic                 mem_rdn_i,
    // bank register access and which one
    input  logic                 bankreg_sel_i,
    input  logic                 slv_addr0_i,
    // bootrom, scrb or via1 request
    input  logic                 int_req_i,
    input  logic [RAMBANK_W-1:0] rambank_i,
    input  logic [ROMBANK_W-1:0] rombank_i,
    input  logic [DATA_W-1:0]    mem_db_i,
    input  logic [DATA_W-1:0]    slv_data_i,
    output logic [DATA_W-1:0]    cpu_db_o
);

    // holds its value when no source is active
    always_ff @(posedge clk6x)
    begin
        if (!mem_rdn_i)
        begin
            // external memory or device
            cpu_db_o <= mem_db_i;
        end
        else if (bankreg_sel_i)
        begin
            if (!slv_addr0_i)
            begin
                cpu_db_o <= rambank_i;
            end
            else
            begin
                // rombank is narrower, zero-extend
                cpu_db_o <= {{(DATA_W-ROMBANK_W){1'b0}}, rombank_i};
            end
        end
        else if (int_req_i)
        begin
            cpu_db_o <= slv_data_i;
        end
    end

endmodule

/* bus_cycle_latch.sv */
// holds the decoded cpu cycle from setup_cs to release_cs and drives the memory bus strobes
`timescale 1ns/10ps

module bus_cycle_latch import bus_pkg::*;
(
    input  logic               clk6x,
    input  logic               resetn,
    // cpu cycle phases
    input  logic               setup_cs_i,
    input  logic               release_wr_i,
    input  logic               release_cs_i,
    // decode of the current cpu address
    input  cpu_cycle_t         cycle_i,
    input  bus_sel_t           sel_i,
    input  logic [MEM_AHW-1:0] mem_abh_i,
    input  logic [ABL_W-1:0]   abl_i,
    // memory bus address
    output logic [MEM_AHW-1:0] mem_abh_o,
    output logic [ABL_W-1:0]   memcpu_abl_o,
    // external chip-selects and strobes, active low
    output logic               sram_csn_o,
    output logic               vera_csn_o,
    output logic               aura_csn_o,
    output logic               enet_csn_o,
    output logic               mem_rdn_o,
    output logic               mem_wrn_o,
    // internal slave requests
    output logic               slv_req_bootrom_o,
    output logic               slv_req_scrb_o,
    output logic               slv_req_via1_o,
    output logic               bankreg_sel_o,
    // latched address and direction for the internal slaves
    output cpu_cycle_t         slv_cycle_o
);

    logic ext_sel;

    // any device on the external memory bus
    assign ext_sel = sel_i.sram || sel_i.vera || sel_i.aura || sel_i.enet;

    // selects and strobes, release_cs last so it wins over setup_cs
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            sram_csn_o <= 1'b1;
            vera_csn_o <= 1'b1;
            aura_csn_o <= 1'b1;
            enet_csn_o <= 1'b1;
            mem_rdn_o <= 1'b1;
            mem_wrn_o <= 1'b1;
            slv_req_bootrom_o <= 1'b0;
            slv_req_scrb_o <= 1'b0;
            slv_req_via1_o <= 1'b0;
            bankreg_sel_o <= 1'b0;
        end
        else
        begin
            if (setup_cs_i)
            begin
                sram_csn_o <= !sel_i.sram;
                vera_csn_o <= !sel_i.vera;
                aura_csn_o <= !sel_i.aura;
                enet_csn_o <= !sel_i.enet;
                mem_rdn_o <= !(ext_sel && cycle_i.rwn);
                // rom area never gets a write strobe
                mem_wrn_o <= !(ext_sel && !cycle_i.rwn && sel_i.wr_allowed);
                slv_req_bootrom_o <= sel_i.bootrom;
                slv_req_scrb_o <= sel_i.scrb;
                slv_req_via1_o <= sel_i.via1;
                bankreg_sel_o <= sel_i.bankreg;
            end
            // early write release gives hold time before cs goes away
            if (release_wr_i)
            begin
                mem_wrn_o <= 1'b1;
            end
            if (release_cs_i)
            begin
                sram_csn_o <= 1'b1;
                vera_csn_o <= 1'b1;
                aura_csn_o <= 1'b1;
                enet_csn_o <= 1'b1;
                mem_rdn_o <= 1'b1;
                mem_wrn_o <= 1'b1;
                slv_req_bootrom_o <= 1'b0;
                slv_req_scrb_o <= 1'b0;
                slv_req_via1_o <= 1'b0;
                bankreg_sel_o <= 1'b0;
            end
        end
    end

    // address payload
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            memcpu_abl_o <= abl_i;
            slv_cycle_o <= cycle_i;
            // high address only moves for sram
            if (sel_i.sram)
            begin
                mem_abh_o <= mem_abh_i;
            end
        end
    end

endmodule

/* bank_registers.sv */
// RAMBANK and ROMBANK registers, written by the cpu at the end of a bank register cycle
`timescale 1ns/10ps

module bank_registers import bus_pkg::*;
(
    input  logic                 clk6x,
    input  logic                 resetn,
    // end of cpu cycle
    input  logic                 release_cs_i,
    // latched bank register select
    input  logic                 bankreg_sel_i,
    // latched address and direction
    input  cpu_cycle_t           cycle_i,
    // cpu write data valid only at release_cs
    input  logic [DATA_W-1:0]    wdata_i,
    // usable ram banks from scrb
    input  logic [DATA_W-1:0]    rambank_mask_i,
    output logic [RAMBANK_W-1:0] rambank_o,
    output logic [ROMBANK_W-1:0] rombank_o
);

    logic bank_wr;

    // write strobe for either register
    assign bank_wr = release_cs_i && bankreg_sel_i && !cycle_i.rwn;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rambank_o <= '0;
            // rom bank 31 after reset
            rombank_o <= ROMBANK_RESET;
        end
        else if (bank_wr)
        begin
            if (!cycle_i.addr[0])
            begin
                // RAMBANK at 0x0000 limited to the fitted ram
                rambank_o <= wdata_i & rambank_mask_i;
            end
            else
            begin
                // ROMBANK at 0x0001 drops the upper data bits
                rombank_o <= wdata_i[ROMBANK_W-1:0];
            end
        end
    end

endmodule

/* cpu_addr_decoder.sv */
// combinational cpu address decode into target selects and sram high address, used by the bus controller
`timescale 1ns/10ps

module cpu_addr_decoder import bus_pkg::*;
(
    // current cpu address and direction
    input  cpu_cycle_t           cycle_i,
    // bank numbers from the bank registers
    input  logic [RAMBANK_W-1:0] rambank_i,
    input  logic [ROMBANK_W-1:0] rombank_i,
    // decode result
    output bus_sel_t             sel_o,
    output logic [MEM_AHW-1:0]   mem_abh_o
);

    logic [CPU_AW-1:0] addr;
    logic [3:0]        io_nibble;

    assign addr = cycle_i.addr;
    // device index inside the i/o page
    assign io_nibble = addr[7:4];

    always_comb
    begin
        // nothing selected unless a region matches
        sel_o = '0;
        sel_o.wr_allowed = 1'b1;
        // low memory mapping as default, only loaded by the latch for sram
        mem_abh_o = {LOWMEM_PAGE_BASE, addr[15:12]};

        if (addr[15:14] == 2'b11)
        begin
            // 0xc000-0xffff, 16k rom window
            sel_o.wr_allowed = 1'b0;
            if (rombank_i[ROMBANK_W-1])
            begin
                // banks 32 and up map to the boot rom inside the fpga
                sel_o.bootrom = 1'b1;
            end
            else
            begin
                // rom banks sit at the top of sram
                sel_o.sram = 1'b1;
                mem_abh_o = {2'b11, rombank_i[ROMBANK_W-2:0], addr[13:12]};
            end
        end
        else if (addr[15:13] == 3'b101)
        begin
            // 0xa000-0xbfff, 8k ram window from the bottom of sram
            sel_o.sram = 1'b1;
            mem_abh_o = {rambank_i, addr[12]};
        end
        else if (addr[15:8] == IO_PAGE)
        begin
            // i/o page, unknown nibbles select nothing
            if (io_nibble == IO_VIA1)
            begin
                sel_o.via1 = 1'b1;
            end
            else if (addr[7:5] == IO_VERA_PREFIX)
            begin
                sel_o.vera = 1'b1;
            end
            else if (io_nibble == IO_AURA)
            begin
                sel_o.aura = 1'b1;
            end
            else if (io_nibble == IO_SCRB)
            begin
                sel_o.scrb = 1'b1;
            end
            else if (io_nibble == IO_ENET)
            begin
                sel_o.enet = 1'b1;
            end
        end
        else if (addr[CPU_AW-1:1] == BANKREG_ADDR_HI)
        begin
            // RAMBANK at 0x0000, ROMBANK at 0x0001
            sel_o.bankreg = 1'b1;
        end
        else
        begin
            // rest of the map is base low memory
            sel_o.sram = 1'b1;
        end
    end

endmodule

/* bus_pkg.sv */
// shared address map constants and bus structs for the 65C816 bus controller, imported by every module
package bus_pkg;

    // cpu side widths
    localparam int CPU_AW = 16;
    localparam int ABL_W = 12;
    localparam int DATA_W = 8;

    // memory high address covers bits 20:12
    localparam int MEM_AHW = 9;

    // bank register widths
    localparam int RAMBANK_W = 8;
    localparam int ROMBANK_W = 6;

    // reset rom bank 31 keeps bit 5 clear and maps the rom window to sram
    localparam logic [ROMBANK_W-1:0] ROMBANK_RESET = 6'd31;

    // upper five sram address bits for base low memory
    localparam logic [4:0] LOWMEM_PAGE_BASE = 5'h17;

    // i/o page at 0x9fxx
    localparam logic [7:0] IO_PAGE = 8'h9F;

    // i/o device nibbles in address bits 7:4
    localparam logic [3:0] IO_VIA1 = 4'h0;
    localparam logic [3:0] IO_AURA = 4'h4;
    localparam logic [3:0] IO_SCRB = 4'h5;
    localparam logic [3:0] IO_ENET = 4'h8;

    // vera covers 0x9f20 and 0x9f30 so only bits 7:5 are compared
    localparam logic [2:0] IO_VERA_PREFIX = 3'b001;

    // address bits 15:1 for the RAMBANK/ROMBANK pair at 0x0000/0x0001
    localparam logic [CPU_AW-2:0] BANKREG_ADDR_HI = '0;

    // decode result with one flag per target
    typedef struct packed {
        logic sram;
        logic vera;
        logic aura;
        logic enet;
        logic bootrom;
        logic scrb;
        logic via1;
        logic bankreg;
        // cleared for the rom area
        logic wr_allowed;
    } bus_sel_t;

    // one cpu bus cycle as seen at setup_cs
    typedef struct packed {
        logic [CPU_AW-1:0] addr;
        // 1 = read, 0 = write
        logic              rwn;
    } cpu_cycle_t;

endpackage
